// File: hdl/bkm_consts.svh
// BKM exponential constants
// Word format and iteration count shared by the RTL, the packages
// and the testbench model
`ifndef BKM_CONSTS_SVH
`define BKM_CONSTS_SVH

// ----------------------------------------
// Fixed-point format
// ----------------------------------------
// Full word width, unsigned
`define BKM_W 32
// Fraction bits, Q4.28
`define BKM_FRAC 28

// ----------------------------------------
// Iteration
// ----------------------------------------
// One step per table entry, n = 0 .. 27
`define BKM_STEPS 28

`endif

// File: hdl/bkm_num_pkg.sv
// BKM numeric types
// Word type and fixed-point constants used by the datapath,
// the log table and the testbench model
`include "bkm_consts.svh"

package bkm_num_pkg;

   // ----------------------------------------
   // Word type
   // ----------------------------------------
   // Arguments, residuals, products and table entries
   typedef logic [`BKM_W-1:0] word_t;

   // ----------------------------------------
   // Constants
   // ----------------------------------------
   // 1.0 in Q4.28
   localparam word_t BKM_ONE = word_t'(1) << `BKM_FRAC;

   // Sum of all ln(1+2^-n) entries, n = 0 .. 27
   // Largest argument the E-mode iteration converges for, about 1.562
   localparam word_t BKM_X_MAX = 32'd419302577;

endpackage

// File: hdl/bkm_ctrl_pkg.sv
// BKM control types
// Sequencer state encoding and the step index type
`include "bkm_consts.svh"

package bkm_ctrl_pkg;

   // ----------------------------------------
   // Step index
   // ----------------------------------------
   // Wide enough for 0 .. BKM_STEPS-1
   typedef logic [$clog2(`BKM_STEPS)-1:0] step_t;

   // ----------------------------------------
   // Sequencer state
   // ----------------------------------------
   typedef enum logic {
      ST_IDLE = 1'b0,
      // Iterating, one step per clock
      ST_RUN  = 1'b1
   } seq_state_t;

endpackage

// File: hdl/bkm_log_table.sv
// BKM log table
// Constant ROM of ln(1+2^-n) in Q4.28, rounded to nearest
// Combinational, zero latency; indices past the last step read zero
`timescale 1ns/100ps

module bkm_log_table
   import bkm_num_pkg::*, bkm_ctrl_pkg::*;
(
   input  step_t idx,
   output word_t ln_val
);

   // Large n: entry collapses to 2^(28-n) once the
   // quadratic term drops below half an LSB
   always_comb begin
      case (idx)
         5'd0:    ln_val = 32'd186065279;
         5'd1:    ln_val = 32'd108841211;
         5'd2:    ln_val = 32'd59899641;
         5'd3:    ln_val = 32'd31617143;
         5'd4:    ln_val = 32'd16273798;
         5'd5:    ln_val = 32'd8260204;
         5'd6:    ln_val = 32'd4161873;
         5'd7:    ln_val = 32'd2089002;
         5'd8:    ln_val = 32'd1046533;
         5'd9:    ln_val = 32'd523777;
         5'd10:   ln_val = 32'd262016;
         5'd11:   ln_val = 32'd131040;
         5'd12:   ln_val = 32'd65528;
         5'd13:   ln_val = 32'd32766;
         // Pure powers of two from here on
         5'd14:   ln_val = 32'd16384;
         5'd15:   ln_val = 32'd8192;
         5'd16:   ln_val = 32'd4096;
         5'd17:   ln_val = 32'd2048;
         5'd18:   ln_val = 32'd1024;
         5'd19:   ln_val = 32'd512;
         5'd20:   ln_val = 32'd256;
         5'd21:   ln_val = 32'd128;
         5'd22:   ln_val = 32'd64;
         5'd23:   ln_val = 32'd32;
         5'd24:   ln_val = 32'd16;
         5'd25:   ln_val = 32'd8;
         5'd26:   ln_val = 32'd4;
         5'd27:   ln_val = 32'd2;
         // Out of table
         default: ln_val = '0;
      endcase
   end

endmodule

// File: hdl/bkm_control_step.sv
// BKM E-mode control step
// One iteration: digit decision from the residual, then
// u -= ln(1+2^-n) and v *= (1+2^-n) when the digit is one
// Purely combinational
`timescale 1ns/100ps

module bkm_control_step
   import bkm_num_pkg::*, bkm_ctrl_pkg::*;
(
   input  word_t u,
   input  word_t v,
   input  step_t idx,
   input  word_t ln_val,
   output word_t u_next,
   output word_t v_next
);

   // ----------------------------------------
   // Digit decision
   // ----------------------------------------
   // Digit is one while the residual still covers the table entry
   logic  digit;
   // v * 2^-n, truncated
   word_t v_shift;
   // Candidate updates
   word_t u_sub;
   word_t v_add;

   assign digit = (u >= ln_val);

   // ----------------------------------------
   // Residual and product update
   // ----------------------------------------
   // Shift by step index, n = 0 doubles v
   assign v_shift = v >> idx;

   // No underflow, guarded by the digit compare
   assign u_sub = u - ln_val;

   // Product stays below 4.77 in Q4.28, no carry out of the word
   assign v_add = v + v_shift;

   always_comb begin
      if (digit) begin
         u_next = u_sub;
         v_next = v_add;
      end else begin
         // Digit zero, both lanes pass through
         u_next = u;
         v_next = v;
      end
   end

endmodule

// File: hdl/bkm_sequencer.sv
// BKM sequencer
// Holds the u and v registers, the step counter and the range flag
// Loads on an accepted start, runs 28 steps, captures result and
// residual and pulses done on the last step
`timescale 1ns/100ps

`include "bkm_consts.svh"

module bkm_sequencer
   import bkm_num_pkg::*, bkm_ctrl_pkg::*;
(
   input  logic  clk,
   input  logic  srst,
   input  logic  start,
   input  word_t x,
   input  word_t u_next,
   input  word_t v_next,
   output step_t idx,
   output word_t u,
   output word_t v,
   output logic  busy,
   output logic  done,
   output logic  range_err,
   output word_t result,
   output word_t residual
);

   // ----------------------------------------
   // Control
   // ----------------------------------------
   seq_state_t state;
   // Start only counts while idle
   logic       accept;
   // Step 27 being written this cycle
   logic       last_step;
   // Range check result, taken at load
   logic       range_flag;

   assign accept    = (state == ST_IDLE) && start;
   assign last_step = (state == ST_RUN) && (idx == step_t'(`BKM_STEPS - 1));

   // Busy follows the run state, so it drops together with done
   assign busy = (state == ST_RUN);

   always_ff @(posedge clk) begin
      if (srst) begin
         state      <= ST_IDLE;
         idx        <= '0;
         done       <= 1'b0;
         range_flag <= 1'b0;
         range_err  <= 1'b0;
         result     <= '0;
         residual   <= '0;
      end else begin
         // Single-cycle strobe
         done <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (accept) begin
                  state      <= ST_RUN;
                  idx        <= '0;
                  range_flag <= (x > BKM_X_MAX);
               end
            end
            ST_RUN: begin
               idx <= idx + 1'b1;
               if (last_step) begin
                  state     <= ST_IDLE;
                  idx       <= '0;
                  done      <= 1'b1;
                  range_err <= range_flag;
                  // Out of range forces a zero result, latency unchanged
                  result    <= range_flag ? '0 : v_next;
                  residual  <= u_next;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // ----------------------------------------
   // Datapath registers
   // ----------------------------------------
   // Load x and 1.0 on start, then one update per run cycle
   always_ff @(posedge clk) begin
      if (accept) begin
         u <= x;
         v <= BKM_ONE;
      end else if (state == ST_RUN) begin
         u <= u_next;
         v <= v_next;
      end
   end

endmodule

// File: hdl/bkm_exp_top.sv
// BKM exponential top level
// Sequencer drives the log table and the control step, which
// feed the next u and v back combinationally
`timescale 1ns/100ps

module bkm_exp_top
   import bkm_num_pkg::*, bkm_ctrl_pkg::*;
(
   input  logic  clk,
   input  logic  srst,
   input  logic  start,
   input  word_t x,
   output logic  busy,
   output logic  done,
   output logic  range_err,
   output word_t result,
   output word_t residual
);

   // ----------------------------------------
   // Internal wires
   // ----------------------------------------
   step_t idx;
   word_t ln_val;
   // Current residual and product
   word_t u;
   word_t v;
   // Next-step values
   word_t u_next;
   word_t v_next;

   // Registers and strobes
   bkm_sequencer i_seq (
      .clk       (clk),
      .srst      (srst),
      .start     (start),
      .x         (x),
      .u_next    (u_next),
      .v_next    (v_next),
      .idx       (idx),
      .u         (u),
      .v         (v),
      .busy      (busy),
      .done      (done),
      .range_err (range_err),
      .result    (result),
      .residual  (residual)
   );

   // ln(1+2^-n) lookup
   bkm_log_table i_table (
      .idx    (idx),
      .ln_val (ln_val)
   );

   // One iteration per clock
   bkm_control_step i_step (
      .u      (u),
      .v      (v),
      .idx    (idx),
      .ln_val (ln_val),
      .u_next (u_next),
      .v_next (v_next)
   );

endmodule

// File: tb/bkm_step_checker.sv
// BKM step checker
// Compares the model's residual and product with the DUT outputs on
// every done, keeps a registered error flag and difference per lane
`timescale 1ns/100ps

module bkm_step_checker
   import bkm_num_pkg::*;
(
   input  logic  clk,
   input  logic  srst,
   input  logic  done,
   input  word_t exp_u,
   input  word_t exp_v,
   input  word_t got_u,
   input  word_t got_v,
   output logic  err_u,
   output logic  err_v,
   output word_t delta_u,
   output word_t delta_v,
   output int    mismatches
);

   // Flags and differences fresh, one cycle after done
   logic checked;

   always_ff @(posedge clk) begin
      if (srst) begin
         checked    <= 1'b0;
         err_u      <= 1'b0;
         err_v      <= 1'b0;
         delta_u    <= '0;
         delta_v    <= '0;
         mismatches <= 0;
      end else begin
         checked <= done;
         if (done) begin
            err_u   <= (got_u != exp_u);
            err_v   <= (got_v != exp_v);
            // Obtained minus expected, wraps for negative differences
            delta_u <= got_u - exp_u;
            delta_v <= got_v - exp_v;
         end
         // Outputs and model hold past done, so the lanes are still valid here
         if (checked) begin
            mismatches <= mismatches + int'(err_u) + int'(err_v);
            if (err_u)
               $display("ERROR checker u lane: expected %h, actual %h, difference %h",
                        exp_u, got_u, delta_u);
            if (err_v)
               $display("ERROR checker v lane: expected %h, actual %h, difference %h",
                        exp_v, got_v, delta_v);
         end
      end
   end

endmodule

// File: tb/bkm_exp_props.sv
// BKM exponential assertions
// Strobe, latency and reset rules on the top level, attached by bind
`timescale 1ns/100ps

module bkm_exp_props
   import bkm_num_pkg::*;
(
   input logic  clk,
   input logic  srst,
   input logic  start,
   input logic  busy,
   input logic  done,
   input logic  range_err,
   input word_t result
);

   // Failed assertions, summed into the testbench verdict
   int fail_count = 0;
   // Edges since an accepted start, zero with no run open
   int since_start;

   always_ff @(posedge clk) begin
      if (srst)
         since_start <= 0;
      else if (start && !busy)
         since_start <= 1;
      else if (done)
         since_start <= 0;
      else if (since_start != 0)
         since_start <= since_start + 1;
   end

   // ----------------------------------------
   // Strobe rules
   // ----------------------------------------
   a_done_pulse: assert property (@(posedge clk) disable iff (srst) done |=> !done)
      else begin
         $error("done held high for more than one cycle");
         fail_count++;
      end

   a_done_not_busy: assert property (@(posedge clk) disable iff (srst) done |-> !busy)
      else begin
         $error("busy high together with done");
         fail_count++;
      end

   // Done sampled 29 edges after the start edge, never later
   a_latency: assert property (@(posedge clk) disable iff (srst)
                               (done |-> since_start == 29) and (since_start <= 29))
      else begin
         $error("done not 29 edges after the accepted start");
         fail_count++;
      end

   // Quiet outputs out of reset
   a_reset: assert property (@(posedge clk)
                             srst |=> (!busy && !done && !range_err && result == '0))
      else begin
         $error("strobes or result not cleared by reset");
         fail_count++;
      end

endmodule

// File: tb/bkm_exp_tb.sv
// BKM exponential testbench
// Directed and LFSR arguments, each checked against a bit-exact model
// of the E-mode iteration, plus range, busy and latency behavior
`timescale 1ns/100ps

`include "bkm_consts.svh"

module bkm_exp_tb
   import bkm_num_pkg::*;
();

   localparam int  LATENCY   = 29;
   // zero 1, directed 4, random 40, range 2, busy 1
   localparam int  N_OPS     = 48;
   localparam int  WD_CYCLES = N_OPS * 40 + 200;
   localparam real SCALE     = 2.0 ** `BKM_FRAC;
   localparam real REL_TOL   = 2.0 ** (-20);

   logic  clk;
   logic  srst;
   logic  start;
   word_t x;
   logic  busy;
   logic  done;
   logic  range_err;
   word_t result;
   word_t residual;

   // Model of the operation in flight
   word_t op_u;
   word_t op_v;
   logic  op_err;
   // Lanes handed to the checker in the done cycle
   word_t chk_u;
   word_t chk_v;
   logic  err_u;
   logic  err_v;
   word_t delta_u;
   word_t delta_v;
   int    chk_mismatches;

   word_t       ln_tab [`BKM_STEPS];
   logic [31:0] lfsr;
   int          errors;
   // Edges from the start edge on
   int          edge_cnt;
   int          total;

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   bkm_exp_top i_dut (
      .clk       (clk),
      .srst      (srst),
      .start     (start),
      .x         (x),
      .busy      (busy),
      .done      (done),
      .range_err (range_err),
      .result    (result),
      .residual  (residual)
   );

   bkm_step_checker i_checker (
      .clk        (clk),
      .srst       (srst),
      .done       (done),
      .exp_u      (chk_u),
      .exp_v      (chk_v),
      .got_u      (residual),
      .got_v      (result),
      .err_u      (err_u),
      .err_v      (err_v),
      .delta_u    (delta_u),
      .delta_v    (delta_v),
      .mismatches (chk_mismatches)
   );

   bind bkm_exp_top bkm_exp_props i_props (
      .clk       (clk),
      .srst      (srst),
      .start     (start),
      .busy      (busy),
      .done      (done),
      .range_err (range_err),
      .result    (result)
   );

   // ----------------------------------------
   // Model and helpers
   // ----------------------------------------
   // Galois LFSR, one shift per bit taken
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   // 29 fresh bits, top bit cleared when past the convergence limit
   task automatic rand_arg(output word_t arg);
      word_t raw;
      raw = '0;
      for (int i = 0; i < 29; i++) begin
         lfsr = lfsr_step(lfsr);
         raw  = {raw[30:0], lfsr[0]};
      end
      if (raw > BKM_X_MAX)
         raw[28] = 1'b0;
      arg = raw;
   endtask

   // Greedy E-mode digits, truncating shift, out of range forces zero
   task automatic model_exp(input word_t arg, output word_t mu, output word_t mv);
      mu = arg;
      mv = BKM_ONE;
      for (int n = 0; n < `BKM_STEPS; n++) begin
         if (mu >= ln_tab[n]) begin
            mu = mu - ln_tab[n];
            mv = mv + (mv >> n);
         end
      end
      if (arg > BKM_X_MAX)
         mv = '0;
   endtask

   task automatic tick();
      @(posedge clk);
      #2;
      edge_cnt++;
   endtask

   task automatic compare_word(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         errors++;
         $display("ERROR %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic compare_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         errors++;
         $display("ERROR %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic launch(input word_t arg);
      model_exp(arg, op_u, op_v);
      op_err   = (arg > BKM_X_MAX);
      start    = 1'b1;
      x        = arg;
      edge_cnt = 0;
      tick();
      start    = 1'b0;
   endtask

   // Returns in the done cycle, where a back-to-back start may follow
   task automatic wait_done(input string name);
      while (!done) begin
         // Run in progress, busy must be up
         compare_flag({name, " busy"}, 1'b1, busy);
         tick();
      end
      chk_u = op_u;
      chk_v = op_v;
      compare_word({name, " result"}, op_v, result);
      compare_word({name, " residual"}, op_u, residual);
      compare_flag({name, " range_err"}, op_err, range_err);
      compare_flag({name, " busy"}, 1'b0, busy);
      if (edge_cnt != LATENCY) begin
         errors++;
         $display("ERROR %s latency: expected %0d, actual %0d", name, LATENCY, edge_cnt);
      end
   endtask

   // Result against the real exponential
   task automatic check_exp(input string name, input word_t arg);
      real want;
      real got;
      want = $exp(real'(arg) / SCALE);
      got  = real'(result) / SCALE;
      if ((got - want > want * REL_TOL) || (want - got > want * REL_TOL)) begin
         errors++;
         $display("ERROR %s exp: expected %f, actual %f", name, want, got);
      end
   endtask

   // ----------------------------------------
   // Tests
   // ----------------------------------------
   task automatic test_zero();
      launch('0);
      wait_done("zero");
      compare_word("zero result", BKM_ONE, result);
      compare_word("zero residual", '0, residual);
   endtask

   task automatic test_directed();
      word_t args [4];
      // ln 2, 1.0, 0.5 and the convergence limit
      args = '{ln_tab[0], BKM_ONE, BKM_ONE >> 1, BKM_X_MAX};
      foreach (args[i]) begin
         launch(args[i]);
         wait_done("directed");
         check_exp("directed", args[i]);
      end
   endtask

   task automatic test_random();
      word_t arg;
      for (int i = 0; i < 40; i++) begin
         rand_arg(arg);
         launch(arg);
         wait_done("random");
      end
      tick();
   endtask

   task automatic test_range();
      launch(BKM_X_MAX + 1);
      wait_done("range high");
      compare_word("range high result", '0, result);
      tick();
      launch(BKM_ONE);
      wait_done("range clear");
   endtask

   task automatic test_busy();
      int extra;
      extra = 0;
      launch(BKM_ONE >> 2);
      repeat (5) tick();
      // Lands mid-run, must be dropped
      start = 1'b1;
      x     = BKM_X_MAX + 1;
      tick();
      start = 1'b0;
      x     = '0;
      wait_done("busy");
      repeat (LATENCY + 5) begin
         tick();
         if (done)
            extra++;
      end
      if (extra != 0) begin
         errors++;
         $display("A start issued while busy produced %0d extra done pulses", extra);
      end
   endtask

   // ----------------------------------------
   // Sequence and verdict
   // ----------------------------------------
   initial begin
      srst     = 1'b1;
      start    = 1'b0;
      x        = '0;
      chk_u    = '0;
      chk_v    = '0;
      errors   = 0;
      edge_cnt = 0;
      lfsr     = 32'hd721c21e;
      for (int n = 0; n < `BKM_STEPS; n++)
         ln_tab[n] = word_t'($rtoi($ln(1.0 + 2.0 ** (-n)) * SCALE + 0.5));
      repeat (8) tick();
      srst = 1'b0;
      compare_flag("reset busy", 1'b0, busy);
      compare_flag("reset done", 1'b0, done);
      compare_word("reset result", '0, result);
      test_zero();
      test_directed();
      test_random();
      test_range();
      test_busy();
      tick();
      total = errors + chk_mismatches + i_dut.i_props.fail_count;
      $display("Errors: testbench %0d, checker %0d, assertions %0d",
               errors, chk_mismatches, i_dut.i_props.fail_count);
      if (total == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

   // Watchdog, sized from the operation count
   initial begin
      repeat (WD_CYCLES) @(posedge clk);
      $display("Timeout: no done within %0d cycles", WD_CYCLES);
      $display("TEST FAILED");
      $finish;
   end

endmodule

// File: bkm_exp.f
+incdir+hdl
hdl/bkm_num_pkg.sv
hdl/bkm_ctrl_pkg.sv
hdl/bkm_log_table.sv
hdl/bkm_control_step.sv
hdl/bkm_sequencer.sv
hdl/bkm_exp_top.sv
tb/bkm_step_checker.sv
tb/bkm_exp_props.sv
tb/bkm_exp_tb.sv

// File: Makefile
# Verilator build and run of the BKM exponential testbench
# make | make run, make lint, make clean

VERILATOR ?= verilator
TOP       ?= bkm_exp_tb
FLIST     ?= bkm_exp.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
RUN_ARGS  ?= +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FLIST)) hdl/bkm_consts.svh
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

# The verdict is the pass line in the log
run: $(SIM)
	./$(SIM) $(RUN_ARGS) | tee $(LOG)
	@grep -qx "TEST OK" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
